// ==== design/erx_pkg.sv ====
`default_nettype none

package erx_pkg;

   // ######################################################################
   // link constants
   // ######################################################################

   // heartbeat counter width, 16-cycle wrap in sim (8 for hardware)
   localparam int heartbeat_width  = 4;
   localparam int packet_bytes     = 5;                          // link bytes per packet
   localparam int byte_count_width = $clog2(packet_bytes + 1);   // holds 0..packet_bytes

   // ######################################################################
   // reset sequencer states
   // ######################################################################

   typedef enum logic [1:0] {
      reset_all = 2'b00,   // pll, idelay and link all held
      start_pll = 2'b01,   // waiting on lock and idelay ready
      active    = 2'b10    // link released
   } erx_state_t;

   // ######################################################################
   // packet word, ctrl byte goes out first on the link
   // ######################################################################

   typedef struct packed {
      logic       write;       // 1 = write request
      logic [6:0] ctrl_mode;   // passed through untouched
   } erx_ctrl_t;

   typedef struct packed {
      erx_ctrl_t   ctrl;
      logic [15:0] addr;
      logic [15:0] data;
   } erx_write_t;

   typedef struct packed {
      erx_ctrl_t   ctrl;
      logic [15:0] addr;
      logic [15:0] src_addr;   // return address for the read data
   } erx_read_t;

   // same 40 bits, view picked by ctrl.write
   typedef union packed {
      erx_write_t wr;
      erx_read_t  rd;
   } erx_packet_u;

endpackage

`default_nettype wire

// ==== design/erx_reset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_reset_sequencer (
   input  logic sys_clk,
   input  logic sys_reset,      // power-on reset
   input  logic soft_reset,     // software link disable
   input  logic pll_locked,     // from link pll, async to sys_clk
   input  logic idelay_ready,   // from input-delay controller
   output logic pll_reset,
   output logic idelay_reset,
   output logic erx_reset       // link reset for the datapath
);

   import erx_pkg::*;

   // ######################################################################
   // heartbeat
   // ######################################################################

   logic [heartbeat_width-1:0] hb_count;   // free running
   logic                       heartbeat;  // one cycle per wrap

   always_ff @(posedge sys_clk or posedge sys_reset)
   begin
      if (sys_reset)
      begin
         hb_count  <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         hb_count  <= hb_count + 1'b1;
         heartbeat <= (hb_count == '0);   // fires right after the wrap
      end
   end

   // two-flop lock synchronizer
   logic lock_meta;
   logic lock_sync;

   always_ff @(posedge sys_clk or posedge sys_reset)
   begin
      if (sys_reset)
      begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else
      begin
         lock_meta <= pll_locked;
         lock_sync <= lock_meta;
      end
   end

   // ######################################################################
   // reset state machine, steps only on heartbeat
   // ######################################################################

   erx_state_t state;

   always_ff @(posedge sys_clk or posedge sys_reset)
   begin
      if (sys_reset)
         state <= reset_all;
      else if (heartbeat)
      begin
         case (state)
            reset_all : if (!soft_reset) state <= start_pll;
            start_pll : if (lock_sync && idelay_ready) state <= active;
            active    : if (soft_reset) state <= reset_all;   // lock loss ignored here
            default   : state <= reset_all;                   // recover from bad encoding
         endcase
      end
   end

   // decoded straight from the state flops
   assign pll_reset    = (state == reset_all);
   assign idelay_reset = (state == reset_all);
   assign erx_reset    = (state != active);

   // only legal encodings ever reach the state register
   a_state_legal : assert property (@(posedge sys_clk) disable iff (sys_reset)
      state inside {reset_all, start_pll, active});

   // link release only via a heartbeat with lock and idelay ready both seen
   a_release_cause : assert property (@(posedge sys_clk) disable iff (sys_reset)
      $fell(erx_reset) |-> $past(heartbeat && lock_sync && idelay_ready));

endmodule

`default_nettype wire

// ==== design/erx_frame_deserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_frame_deserializer (
   input  logic                sys_clk,
   input  logic                link_reset,    // sys_reset or erx_reset
   input  logic                rx_frame,      // byte valid level
   input  logic [7:0]          rx_data,
   output erx_pkg::erx_packet_u packet,       // held until next pulse
   output logic                packet_valid,  // one cycle
   output logic                short_frame    // one cycle per dropped partial frame
);

   import erx_pkg::*;

   // ######################################################################
   // byte collection
   // ######################################################################

   erx_packet_u                 shift_reg;    // msb byte first
   logic [byte_count_width-1:0] byte_count;   // bytes held in shift_reg
   logic [byte_count_width-1:0] count_base;   // count after full/drop cleanup
   logic                        frame_q;      // rx_frame from last edge
   logic                        packet_full;

   assign packet_full = (byte_count == packet_bytes);

   // full word rolls over and a dead frame drops its partial bytes
   always_comb
   begin
      if (packet_full || !frame_q)
         count_base = '0;
      else
         count_base = byte_count;
   end

   // payload path
   always_ff @(posedge sys_clk)
   begin
      if (rx_frame)
         shift_reg <= {shift_reg[31:0], rx_data};   // shift in new byte at lsb
      if (packet_full)
         packet <= shift_reg;                       // word stays put until next one
   end

   // ######################################################################
   // control
   // ######################################################################

   always_ff @(posedge sys_clk or posedge link_reset)
   begin
      if (link_reset)
      begin
         byte_count   <= '0;
         frame_q      <= 1'b0;
         packet_valid <= 1'b0;
         short_frame  <= 1'b0;
      end
      else
      begin
         frame_q      <= rx_frame;
         packet_valid <= packet_full;
         // frame ended last cycle with 1..4 bytes
         short_frame  <= !frame_q && (byte_count != '0) && !packet_full;
         if (rx_frame)
            byte_count <= count_base + 1'b1;
         else
            byte_count <= count_base;
      end
   end

   // full and partial cases never coincide
   a_valid_short_excl : assert property (@(posedge sys_clk) disable iff (link_reset)
      !(packet_valid && short_frame));

endmodule

`default_nettype wire

// ==== design/erx_packet_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_packet_decoder (
   input  logic                 sys_clk,
   input  logic                 link_reset,
   input  erx_pkg::erx_packet_u packet,
   input  logic                 packet_valid,
   output logic                 wr_valid,      // one cycle per write packet
   output logic                 rd_valid,      // one cycle per read packet
   output logic [15:0]          wr_addr,
   output logic [15:0]          wr_data,
   output logic [15:0]          rd_addr,
   output logic [15:0]          rd_src_addr,
   output logic [6:0]           ctrl_mode
);

   logic is_write;   // view select, ctrl byte same in both views

   assign is_write = packet.wr.ctrl.write;

   // ######################################################################
   // request fields, held between pulses
   // ######################################################################

   always_ff @(posedge sys_clk)
   begin
      if (packet_valid)
      begin
         ctrl_mode <= packet.wr.ctrl.ctrl_mode;   // either kind
         if (is_write)
         begin
            wr_addr <= packet.wr.addr;
            wr_data <= packet.wr.data;
         end
         else
         begin
            rd_addr     <= packet.rd.addr;
            rd_src_addr <= packet.rd.src_addr;   // where read data goes back
         end
      end
   end

   // strobes
   always_ff @(posedge sys_clk or posedge link_reset)
   begin
      if (link_reset)
      begin
         wr_valid <= 1'b0;
         rd_valid <= 1'b0;
      end
      else
      begin
         wr_valid <= packet_valid && is_write;
         rd_valid <= packet_valid && !is_write;
      end
   end

   // one request kind per packet
   a_wr_rd_excl : assert property (@(posedge sys_clk) disable iff (link_reset)
      !(wr_valid && rd_valid));

endmodule

`default_nettype wire

// ==== design/erx_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_frontend (
   input  logic        sys_clk,
   input  logic        sys_reset,
   input  logic        soft_reset,
   input  logic        pll_locked,
   input  logic        idelay_ready,
   input  logic        rx_frame,
   input  logic [7:0]  rx_data,
   output logic        pll_reset,
   output logic        idelay_reset,
   output logic        erx_reset,
   output logic        wr_valid,
   output logic [15:0] wr_addr,
   output logic [15:0] wr_data,
   output logic        rd_valid,
   output logic [15:0] rd_addr,
   output logic [15:0] rd_src_addr,
   output logic [6:0]  ctrl_mode,
   output logic        short_frame
);

   import erx_pkg::*;

   // ######################################################################
   // internal wires
   // ######################################################################

   logic        link_reset;     // datapath async reset
   erx_packet_u packet;         // deserializer -> decoder
   logic        packet_valid;

   assign link_reset = sys_reset | erx_reset;

   // control: reset sequencing
   erx_reset_sequencer erx_reset_sequencer_inst (
      .sys_clk      (sys_clk),
      .sys_reset    (sys_reset),
      .soft_reset   (soft_reset),
      .pll_locked   (pll_locked),
      .idelay_ready (idelay_ready),
      .pll_reset    (pll_reset),
      .idelay_reset (idelay_reset),
      .erx_reset    (erx_reset)
   );

   // datapath stage 1, bytes to packet words
   erx_frame_deserializer erx_frame_deserializer_inst (
      .sys_clk      (sys_clk),
      .link_reset   (link_reset),
      .rx_frame     (rx_frame),
      .rx_data      (rx_data),
      .packet       (packet),
      .packet_valid (packet_valid),
      .short_frame  (short_frame)
   );

   // datapath stage 2, words to requests
   erx_packet_decoder erx_packet_decoder_inst (
      .sys_clk      (sys_clk),
      .link_reset   (link_reset),
      .packet       (packet),
      .packet_valid (packet_valid),
      .wr_valid     (wr_valid),
      .rd_valid     (rd_valid),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .rd_addr      (rd_addr),
      .rd_src_addr  (rd_src_addr),
      .ctrl_mode    (ctrl_mode)
   );

endmodule

`default_nettype wire

// ==== test/erx_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_frontend_tb;

   import erx_pkg::*;

   localparam int num_writes = 50;
   localparam int num_mixed  = 40;
   localparam int num_short  = 4;
   localparam int num_drop   = 3;   // packets sent into a held link
   localparam int hb_cycles  = 1 << heartbeat_width;
   // bring-up for two reset sequences plus 10 cycles per packet plus margin
   localparam int budget = 2 * 4 * hb_cycles
                         + 10 * (num_writes + num_mixed + 2 * num_short + num_drop + 1) + 200;

   logic        sys_clk = 1'b0;
   logic        sys_reset, soft_reset, pll_locked, idelay_ready, rx_frame;
   logic [7:0]  rx_data;
   logic        pll_reset, idelay_reset, erx_reset, wr_valid, rd_valid, short_frame;
   logic [15:0] wr_addr, wr_data, rd_addr, rd_src_addr;
   logic [6:0]  ctrl_mode;

   erx_packet_u exp_q[$];          // expected packets in send order
   int          due_q[$];          // cycle each pulse is due
   int          cycle_count  = 0;
   int          pulse_count  = 0;
   int          expect_count = 0;
   bit          short_allowed = 1'b0;
   string       test_name = "sys_reset";

   erx_frontend erx_frontend_inst (.*);

   always #5 sys_clk = ~sys_clk;   // 10 ns

   always @(posedge sys_clk)
      cycle_count <= cycle_count + 1;

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic mismatch(input string field, input logic [15:0] exp, input logic [15:0] act);
      fail_run($sformatf("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
                         test_name, field, exp, act));
   endtask

   // ######################################################################
   // reference model and compare tasks
   // ######################################################################

   // bytes in link order fill the word from the msb down
   function automatic erx_packet_u ref_packet(input logic [7:0] b [packet_bytes]);
      erx_packet_u p;
      p.wr.ctrl = b[0];              // ctrl byte sits in the same place in both views
      p.wr.addr = {b[1], b[2]};      // addr hi then lo
      p.wr.data = {b[3], b[4]};      // src_addr in the read view
      return p;
   endfunction

   task automatic check_write(input erx_packet_u exp);
      if (wr_addr !== exp.wr.addr)
         mismatch("wr_addr", exp.wr.addr, wr_addr);
      if (wr_data !== exp.wr.data)
         mismatch("wr_data", exp.wr.data, wr_data);
      if (ctrl_mode !== exp.wr.ctrl.ctrl_mode)
         mismatch("ctrl_mode", exp.wr.ctrl.ctrl_mode, ctrl_mode);
   endtask

   task automatic check_read(input erx_packet_u exp);
      if (rd_addr !== exp.rd.addr)
         mismatch("rd_addr", exp.rd.addr, rd_addr);
      if (rd_src_addr !== exp.rd.src_addr)
         mismatch("rd_src_addr", exp.rd.src_addr, rd_src_addr);
      if (ctrl_mode !== exp.rd.ctrl.ctrl_mode)
         mismatch("ctrl_mode", exp.rd.ctrl.ctrl_mode, ctrl_mode);
   endtask

   task automatic check_flag(input string field, input logic exp, input logic act);
      if (act !== exp)
         mismatch(field, exp, act);
   endtask

   // monitor sees values from before this edge's updates
   always @(posedge sys_clk)
   begin
      if (!sys_reset && (wr_valid || rd_valid))
      begin
         if (exp_q.size() == 0)
            fail_run($sformatf("%s: %s pulse with no packet expected", test_name,
                               wr_valid ? "write" : "read"));
         else if (cycle_count != due_q[0])
            mismatch("pulse cycle", due_q[0], cycle_count);
         else if (wr_valid !== exp_q[0].wr.ctrl.write)
            mismatch("write pulse", exp_q[0].wr.ctrl.write, wr_valid);
         if (wr_valid)
            check_write(exp_q[0]);
         else
            check_read(exp_q[0]);
         void'(exp_q.pop_front());
         void'(due_q.pop_front());
         pulse_count++;
      end
      if (short_frame && !short_allowed)
         fail_run($sformatf("%s: short_frame pulse with no short frame sent", test_name));
   end

   // ######################################################################
   // stimulus helpers driven on the falling edge
   // ######################################################################

   task automatic send_packet(input logic is_write, input bit counted);
      logic [7:0] b [packet_bytes];
      for (int i = 0; i < packet_bytes; i++)
         b[i] = 8'($urandom);
      b[0][7] = is_write;
      for (int i = 0; i < packet_bytes; i++)
      begin
         @(negedge sys_clk);
         rx_frame = 1'b1;
         rx_data  = b[i];
      end
      if (counted)
      begin
         exp_q.push_back(ref_packet(b));
         due_q.push_back(cycle_count + 3);   // byte sampled next edge and pulse 2 after
         expect_count++;
      end
   endtask

   task automatic end_frame(input int gap);
      repeat (gap)
      begin
         @(negedge sys_clk);
         rx_frame = 1'b0;
         rx_data  = 8'($urandom);   // don't care while low
      end
   endtask

   task automatic drain();
      end_frame(8);                 // last pulse lands within 4 cycles
      if (exp_q.size() != 0)
         fail_run($sformatf("%s: packet expected but queue not drained", test_name));
      if (pulse_count != expect_count)
         mismatch("pulse count", expect_count, pulse_count);
   endtask

   task automatic wait_reset(input string what, input logic level, input int limit);
      int n;
      n = 0;
      while (((what == "pll_reset") ? pll_reset : erx_reset) !== level)
      begin
         if (n == limit)
            fail_run($sformatf("%s: %s not %0b after %0d cycles", test_name, what, level, n));
         @(negedge sys_clk);
         n++;
      end
   endtask

   // ######################################################################
   // test sequence
   // ######################################################################

   initial
   begin
      erx_state_t st;
      void'($urandom(32'h6672_7c02));
      sys_reset    = 1'b1;
      soft_reset   = 1'b0;
      pll_locked   = 1'b1;
      idelay_ready = 1'b0;
      rx_frame     = 1'b0;
      rx_data      = 8'h00;
      @(negedge sys_clk);
      check_flag("pll_reset", 1'b1, pll_reset);
      check_flag("idelay_reset", 1'b1, idelay_reset);
      check_flag("erx_reset", 1'b1, erx_reset);
      check_flag("valid", 1'b0, wr_valid | rd_valid | short_frame);
      @(negedge sys_clk);
      sys_reset = 1'b0;             // two cycles in reset

      test_name = "bringup";
      wait_reset("pll_reset", 1'b0, 20);
      test_name = "held_in_start";
      repeat (100)
      begin
         @(negedge sys_clk);
         check_flag("erx_reset", 1'b1, erx_reset);   // no idelay ready yet
         check_flag("pll_reset", 1'b0, pll_reset);
         check_flag("idelay_reset", 1'b0, idelay_reset);
      end
      idelay_ready = 1'b1;
      wait_reset("erx_reset", 1'b0, 40);
      st = erx_frontend_inst.erx_reset_sequencer_inst.state;
      $display("[INFO] %s: link up, sequencer in %s", test_name, st.name());

      test_name = "writes";          // one long frame
      repeat (num_writes)
         send_packet(1'b1, 1'b1);
      drain();

      test_name = "mixed";
      repeat (num_mixed)
      begin
         send_packet(1'($urandom), 1'b1);
         end_frame(1 + $urandom_range(4));
      end
      drain();

      test_name = "short_frame";
      repeat (num_short)
      begin
         short_allowed = 1'b1;
         repeat (1 + $urandom_range(3))
         begin
            @(negedge sys_clk);
            rx_frame = 1'b1;
            rx_data  = 8'($urandom);
         end
         end_frame(3);              // flag due after second low sample
         check_flag("short_frame", 1'b1, short_frame);
         end_frame(1);
         check_flag("short_frame", 1'b0, short_frame);
         short_allowed = 1'b0;
         send_packet(1'($urandom), 1'b1);
         end_frame(2);
      end
      drain();

      test_name = "soft_reset";
      soft_reset = 1'b1;
      wait_reset("erx_reset", 1'b1, 20);
      check_flag("pll_reset", 1'b1, pll_reset);         // back in reset_all
      check_flag("idelay_reset", 1'b1, idelay_reset);
      repeat (num_drop)
      begin
         send_packet(1'($urandom), 1'b0);   // link held so nothing comes out
         end_frame(2);
      end
      soft_reset = 1'b0;
      wait_reset("erx_reset", 1'b0, 40);
      send_packet(1'($urandom), 1'b1);
      drain();

      if (exp_q.size() == 0 && pulse_count == expect_count)
      begin
         $display("TEST RESULT: PASS");
         $finish;
      end
      else
         fail_run("pulses left over at end of run");
   end

   // watchdog
   initial
   begin
      #(budget * 10);
      fail_run($sformatf("watchdog: run still going after %0d cycles", budget));
   end

endmodule

`default_nettype wire

// ==== project.f ====
design/erx_pkg.sv
design/erx_reset_sequencer.sv
design/erx_frame_deserializer.sv
design/erx_packet_decoder.sv
design/erx_frontend.sv
test/erx_frontend_tb.sv

// ==== Makefile ====
TOP = erx_frontend_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
